// File: rtl/rmii_rx_pkg.sv
`default_nettype none

package rmii_rx_pkg;

    // Frame framing octets
    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam int          FCS_BYTES     = 4;

    // Reflected CRC-32
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    localparam int FRAME_FIFO_DEPTH    = 16;
    localparam int PAYLOAD_FIFO_DEPTH  = 128;
    localparam int OUTBOUND_FIFO_DEPTH = 256;

    typedef struct packed {
        logic       error;
        logic       last;
        logic [7:0] data;
    } frame_word_t;

    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } payload_word_t;

    typedef enum logic [1:0] {
        PARSE_IDLE,
        PARSE_PREAMBLE,
        PARSE_BODY,
        PARSE_DROP
    } parser_state_t;

    typedef enum logic [1:0] {
        SLOT_WAIT,
        SLOT_MOVE,
        SLOT_FLUSH
    } slot_state_t;

endpackage

`default_nettype wire

// File: rtl/rmii_byte_packager.sv
`default_nettype none

module rmii_byte_packager (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire [1:0]                 rmii_receive_data,
    input  wire                       rmii_receive_data_enable,
    input  wire                       rmii_receive_data_error,
    output rmii_rx_pkg::frame_word_t  packaged_data,
    output logic                      packaged_data_valid
);

    logic [7:0] shift_register;
    logic [7:0] assembled_byte;
    logic [7:0] pending_byte;
    logic [1:0] dibit_count;
    logic       pending_valid;
    logic       error_seen;

    // Dibits arrive least significant first
    assign assembled_byte = {rmii_receive_data, shift_register[7:2]};

    always_ff @(posedge clock) begin
        if (rmii_receive_data_enable) begin
            shift_register <= assembled_byte;
        end
        if (rmii_receive_data_enable && dibit_count == 2'd3) begin
            pending_byte  <= assembled_byte;
            packaged_data <= '{error: 1'b0, last: 1'b0, data: pending_byte};
        end else if (!rmii_receive_data_enable) begin
            packaged_data <= '{error: error_seen, last: 1'b1, data: pending_byte};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dibit_count         <= '0;
            pending_valid       <= 1'b0;
            error_seen          <= 1'b0;
            packaged_data_valid <= 1'b0;
        end else begin
            packaged_data_valid <= 1'b0;
            if (rmii_receive_data_enable) begin
                dibit_count <= dibit_count + 2'd1;
                error_seen  <= error_seen || rmii_receive_data_error;
                if (dibit_count == 2'd3) begin
                    // Previous byte is not the last one, release it
                    pending_valid       <= 1'b1;
                    packaged_data_valid <= pending_valid;
                end
            end else begin
                dibit_count   <= '0;
                error_seen    <= 1'b0;
                pending_valid <= 1'b0;
                // Carrier gone, so the held byte closes the frame
                packaged_data_valid <= pending_valid;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire              clock,
    input  wire              rst_n,
    input  wire              flush,
    input  wire              write_enable,
    input  wire [WIDTH-1:0]  write_data,
    input  wire              read_enable,
    output logic [WIDTH-1:0] read_data,
    output logic             read_data_valid,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]           memory [DEPTH];
    logic [$clog2(DEPTH)-1:0]   write_pointer;
    logic [$clog2(DEPTH)-1:0]   read_pointer;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_write;
    logic                       do_read;

    assign empty    = count == '0;
    assign full     = int'(count) == DEPTH;
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
        if (do_read) begin
            read_data <= memory[read_pointer];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            count           <= '0;
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= do_read;
            if (do_write) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= read_pointer + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer must pace itself against this FIFO
    no_write_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        write_enable |-> !full);

endmodule

`default_nettype wire

// File: rtl/frame_check_sequence_generator.sv
`default_nettype none

module frame_check_sequence_generator (
    input  wire         clock,
    input  wire         rst_n,
    input  wire [7:0]   data,
    input  wire         data_enable,
    input  wire         data_last,
    output logic [31:0] checksum,
    output logic        checksum_valid
);

    logic [31:0] crc_register;
    logic [31:0] crc_next;

    // One byte, bit by bit, LSB first
    always_comb begin
        crc_next = crc_register;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ rmii_rx_pkg::CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (data_enable && data_last) begin
            checksum <= ~crc_next;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc_register   <= rmii_rx_pkg::CRC_INIT;
            checksum_valid <= 1'b0;
        end else begin
            checksum_valid <= data_enable && data_last;
            if (data_enable) begin
                crc_register <= data_last ? rmii_rx_pkg::CRC_INIT : crc_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ethernet_packet_parser.sv
`default_nettype none

module ethernet_packet_parser (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire rmii_rx_pkg::frame_word_t data,
    input  wire                         data_enable,
    input  wire                         receive_slot_empty,
    input  wire [31:0]                  checksum_result,
    input  wire                         checksum_result_enable,
    output logic                        data_ready,
    output logic [7:0]                  checksum_data,
    output logic                        checksum_data_valid,
    output logic                        checksum_data_last,
    output rmii_rx_pkg::payload_word_t  packet_data,
    output logic                        packet_data_valid,
    output logic                        good_packet,
    output logic                        bad_packet
);

    rmii_rx_pkg::parser_state_t              state;
    logic [8*rmii_rx_pkg::FCS_BYTES-1:0]     delay_line;
    logic [2:0]                              body_count;
    logic                                    frame_error;
    logic                                    verdict_pending;
    logic                                    body_byte;
    logic                                    body_full;
    logic                                    fcs_match;

    // Hold off reads until the CRC verdict is in
    assign data_ready = !verdict_pending;
    assign body_byte  = data_enable && state == rmii_rx_pkg::PARSE_BODY;
    assign body_full  = int'(body_count) == rmii_rx_pkg::FCS_BYTES;
    assign fcs_match  = checksum_result == delay_line;

    //////////////////////////////
    // Frame state
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state               <= rmii_rx_pkg::PARSE_IDLE;
            body_count          <= '0;
            verdict_pending     <= 1'b0;
            checksum_data_valid <= 1'b0;
            packet_data_valid   <= 1'b0;
            good_packet         <= 1'b0;
            bad_packet          <= 1'b0;
        end else begin
            checksum_data_valid <= body_byte && body_full;
            packet_data_valid   <= body_byte && body_full;
            good_packet <= checksum_result_enable && !frame_error && fcs_match;
            bad_packet  <= (checksum_result_enable && (frame_error || !fcs_match))
                           || (body_byte && data.last && !body_full);
            if (checksum_result_enable) begin
                verdict_pending <= 1'b0;
            end
            if (data_enable) begin
                case (state)
                    rmii_rx_pkg::PARSE_IDLE: begin
                        if (!data.last) begin
                            state <= (data.data == rmii_rx_pkg::PREAMBLE_BYTE) ?
                                     rmii_rx_pkg::PARSE_PREAMBLE : rmii_rx_pkg::PARSE_DROP;
                        end
                    end
                    rmii_rx_pkg::PARSE_PREAMBLE: begin
                        if (data.last) begin
                            state <= rmii_rx_pkg::PARSE_IDLE;
                        end else if (data.data == rmii_rx_pkg::SFD_BYTE) begin
                            // Busy payload slot means drop
                            state <= receive_slot_empty ?
                                     rmii_rx_pkg::PARSE_BODY : rmii_rx_pkg::PARSE_DROP;
                        end else if (data.data != rmii_rx_pkg::PREAMBLE_BYTE) begin
                            state <= rmii_rx_pkg::PARSE_DROP;
                        end
                    end
                    rmii_rx_pkg::PARSE_BODY: begin
                        if (!body_full) begin
                            body_count <= body_count + 3'd1;
                        end
                        if (data.last) begin
                            state           <= rmii_rx_pkg::PARSE_IDLE;
                            body_count      <= '0;
                            verdict_pending <= body_full;
                        end
                    end
                    default: begin
                        if (data.last) begin
                            state <= rmii_rx_pkg::PARSE_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // FCS delay line
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (body_byte) begin
            delay_line         <= {data.data, delay_line[8*rmii_rx_pkg::FCS_BYTES-1:8]};
            checksum_data      <= delay_line[7:0];
            checksum_data_last <= data.last;
            packet_data.data   <= delay_line[7:0];
            packet_data.last   <= data.last;
            if (data.last) begin
                frame_error <= data.error;
            end
        end
    end

    // One verdict per frame, never both at once
    single_verdict: assert property (@(posedge clock) disable iff (!rst_n)
        !(good_packet && bad_packet));

endmodule

`default_nettype wire

// File: rtl/receive_slot_handler.sv
`default_nettype none

module receive_slot_handler (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire                           good_packet,
    input  wire                           bad_packet,
    input  wire rmii_rx_pkg::payload_word_t data,
    input  wire                           data_enable,
    input  wire                           outbound_full,
    output logic                          fifo_flush,
    output logic                          pop,
    output rmii_rx_pkg::payload_word_t    push_data,
    output logic                          push_data_valid
);

    rmii_rx_pkg::slot_state_t state;
    logic                     pop_pending;

    // At most one word in flight, so a free outbound slot is enough
    assign pop             = state == rmii_rx_pkg::SLOT_MOVE && !outbound_full && !pop_pending;
    assign fifo_flush      = state == rmii_rx_pkg::SLOT_FLUSH;
    assign push_data       = data;
    assign push_data_valid = data_enable && state == rmii_rx_pkg::SLOT_MOVE;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= rmii_rx_pkg::SLOT_WAIT;
            pop_pending <= 1'b0;
        end else begin
            pop_pending <= pop;
            case (state)
                rmii_rx_pkg::SLOT_WAIT: begin
                    if (good_packet) begin
                        state <= rmii_rx_pkg::SLOT_MOVE;
                    end else if (bad_packet) begin
                        state <= rmii_rx_pkg::SLOT_FLUSH;
                    end
                end
                rmii_rx_pkg::SLOT_MOVE: begin
                    if (data_enable && data.last) begin
                        state <= rmii_rx_pkg::SLOT_WAIT;
                    end
                end
                default: begin
                    state <= rmii_rx_pkg::SLOT_WAIT;
                end
            endcase
        end
    end

    // Parser must drop frames while the slot is still draining
    no_verdict_while_moving: assert property (@(posedge clock) disable iff (!rst_n)
        state == rmii_rx_pkg::SLOT_MOVE |-> !(good_packet || bad_packet));

endmodule

`default_nettype wire

// File: rtl/rmii_port.sv
`default_nettype none

module rmii_port (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire [1:0]                   rmii_receive_data,
    input  wire                         rmii_receive_data_enable,
    input  wire                         rmii_receive_data_error,
    input  wire                         receive_data_enable,
    output rmii_rx_pkg::payload_word_t  receive_data,
    output logic                        receive_data_valid
);

    rmii_rx_pkg::frame_word_t   packaged_data;
    rmii_rx_pkg::frame_word_t   frame_word;
    rmii_rx_pkg::payload_word_t packet_data;
    rmii_rx_pkg::payload_word_t payload_word;
    rmii_rx_pkg::payload_word_t push_data;
    logic                       packaged_data_valid;
    logic                       frame_word_valid;
    logic                       parser_ready;
    logic [7:0]                 checksum_data;
    logic                       checksum_data_valid;
    logic                       checksum_data_last;
    logic [31:0]                checksum;
    logic                       checksum_valid;
    logic                       packet_data_valid;
    logic                       payload_empty;
    logic                       payload_word_valid;
    logic                       payload_flush;
    logic                       payload_pop;
    logic                       good_packet;
    logic                       bad_packet;
    logic                       push_data_valid;
    logic                       outbound_full;

    //////////////////////////////
    // PHY side
    //////////////////////////////
    rmii_byte_packager rmii_byte_packager (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .packaged_data            (packaged_data),
        .packaged_data_valid      (packaged_data_valid)
    );

    sync_fifo #(
        .WIDTH ($bits(rmii_rx_pkg::frame_word_t)),
        .DEPTH (rmii_rx_pkg::FRAME_FIFO_DEPTH)
    ) frame_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (1'b0),
        .write_enable    (packaged_data_valid),
        .write_data      (packaged_data),
        .read_enable     (parser_ready),
        .read_data       (frame_word),
        .read_data_valid (frame_word_valid),
        .empty           (),
        .full            ()
    );

    //////////////////////////////
    // Parse and check
    //////////////////////////////
    ethernet_packet_parser ethernet_packet_parser (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .data                   (frame_word),
        .data_enable            (frame_word_valid),
        .receive_slot_empty     (payload_empty),
        .checksum_result        (checksum),
        .checksum_result_enable (checksum_valid),
        .data_ready             (parser_ready),
        .checksum_data          (checksum_data),
        .checksum_data_valid    (checksum_data_valid),
        .checksum_data_last     (checksum_data_last),
        .packet_data            (packet_data),
        .packet_data_valid      (packet_data_valid),
        .good_packet            (good_packet),
        .bad_packet             (bad_packet)
    );

    frame_check_sequence_generator frame_check_sequence_generator (
        .clock          (clock),
        .rst_n          (rst_n),
        .data           (checksum_data),
        .data_enable    (checksum_data_valid),
        .data_last      (checksum_data_last),
        .checksum       (checksum),
        .checksum_valid (checksum_valid)
    );

    //////////////////////////////
    // Payload slot and host side
    //////////////////////////////
    sync_fifo #(
        .WIDTH ($bits(rmii_rx_pkg::payload_word_t)),
        .DEPTH (rmii_rx_pkg::PAYLOAD_FIFO_DEPTH)
    ) payload_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (payload_flush),
        .write_enable    (packet_data_valid),
        .write_data      (packet_data),
        .read_enable     (payload_pop),
        .read_data       (payload_word),
        .read_data_valid (payload_word_valid),
        .empty           (payload_empty),
        .full            ()
    );

    receive_slot_handler receive_slot_handler (
        .clock           (clock),
        .rst_n           (rst_n),
        .good_packet     (good_packet),
        .bad_packet      (bad_packet),
        .data            (payload_word),
        .data_enable     (payload_word_valid),
        .outbound_full   (outbound_full),
        .fifo_flush      (payload_flush),
        .pop             (payload_pop),
        .push_data       (push_data),
        .push_data_valid (push_data_valid)
    );

    sync_fifo #(
        .WIDTH ($bits(rmii_rx_pkg::payload_word_t)),
        .DEPTH (rmii_rx_pkg::OUTBOUND_FIFO_DEPTH)
    ) outbound_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (1'b0),
        .write_enable    (push_data_valid),
        .write_data      (push_data),
        .read_enable     (receive_data_enable),
        .read_data       (receive_data),
        .read_data_valid (receive_data_valid),
        .empty           (),
        .full            (outbound_full)
    );

endmodule

`default_nettype wire

// File: verif/rmii_frame_tasks.svh
`ifndef RMII_FRAME_TASKS_SVH
`define RMII_FRAME_TASKS_SVH

typedef logic [7:0] byte_queue_t[$];
typedef rmii_rx_pkg::payload_word_t word_queue_t[$];

// Software style CRC-32, byte folded into the low bits first
function automatic logic [31:0] reference_crc(input byte_queue_t bytes);
    logic [31:0] crc;
    crc = rmii_rx_pkg::CRC_INIT;
    foreach (bytes[n]) begin
        crc = crc ^ {24'h000000, bytes[n]};
        repeat (8) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ rmii_rx_pkg::CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
    end
    return ~crc;
endfunction

task automatic random_payload(input int length, output byte_queue_t payload);
    payload = {};
    repeat (length) begin
        payload.push_back(8'($urandom));
    end
endtask

// Preamble, SFD, payload, then FCS least significant byte first
task automatic build_frame(input byte_queue_t payload, output byte_queue_t frame);
    logic [31:0] fcs;
    fcs = reference_crc(payload);
    frame = {};
    repeat (7) begin
        frame.push_back(rmii_rx_pkg::PREAMBLE_BYTE);
    end
    frame.push_back(rmii_rx_pkg::SFD_BYTE);
    foreach (payload[i]) begin
        frame.push_back(payload[i]);
    end
    for (int i = 0; i < rmii_rx_pkg::FCS_BYTES; i++) begin
        frame.push_back(fcs[8*i +: 8]);
    end
endtask

// One dibit per clock, error raised only on dibit error_dibit (-1 for none)
task automatic drive_frame(input byte_queue_t frame, input int error_dibit, input int gap);
    logic [7:0] octet;
    for (int i = 0; i < frame.size(); i++) begin
        octet = frame[i];
        for (int d = 0; d < 4; d++) begin
            rmii_receive_data        = octet[2*d +: 2];
            rmii_receive_data_enable = 1'b1;
            rmii_receive_data_error  = (4*i + d == error_dibit);
            @(posedge clock);
            #1;
        end
    end
    rmii_receive_data        = 2'b00;
    rmii_receive_data_enable = 1'b0;
    rmii_receive_data_error  = 1'b0;
    repeat (gap) begin
        @(posedge clock);
        #1;
    end
endtask

// Reads until a word with last or until max_cycles have passed
task automatic collect_frame(input int max_cycles, output word_queue_t words);
    int waited;
    words   = {};
    waited  = 0;
    receive_data_enable = 1'b1;
    while (waited < max_cycles) begin
        @(posedge clock);
        #1;
        waited++;
        if (receive_data_valid) begin
            words.push_back(receive_data);
            if (receive_data.last) begin
                break;
            end
        end
    end
    receive_data_enable = 1'b0;
endtask

`endif

// File: verif/rmii_port_tb.sv
`default_nettype none

module rmii_port_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int COLLECT_CYCLES = 600;

    logic                       clock;
    logic                       rst_n;
    logic [1:0]                 rmii_receive_data;
    logic                       rmii_receive_data_enable;
    logic                       rmii_receive_data_error;
    logic                       receive_data_enable;
    rmii_rx_pkg::payload_word_t receive_data;
    logic                       receive_data_valid;
    int                         error_count;
    int                         check_count;
    int                         cycle_count;
    logic                       no_output_expected;

    `include "rmii_frame_tasks.svh"

    rmii_port dut0 (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data_enable      (receive_data_enable),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid)
    );

    always #5 clock = ~clock;

    // Generous bound over all tests
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (no_output_expected && receive_data_valid) begin
            error_count++;
            $display("[ERROR] receive_data_valid: expected 0x0 got 0x1");
        end
    end

    task automatic check_frame(input string label, input byte_queue_t expected,
                               input word_queue_t words);
        check_count++;
        if (words.size() != expected.size()) begin
            error_count++;
            $display("[ERROR] %s frame length: expected 0x%0h got 0x%0h",
                     label, expected.size(), words.size());
        end
        for (int i = 0; i < expected.size() && i < words.size(); i++) begin
            check_count++;
            if (words[i].data != expected[i]) begin
                error_count++;
                $display("[ERROR] %s receive_data.data[%0d]: expected 0x%02h got 0x%02h",
                         label, i, expected[i], words[i].data);
            end
            if (words[i].last != (i == expected.size() - 1)) begin
                error_count++;
                $display("[ERROR] %s receive_data.last[%0d]: expected 0x%0h got 0x%0h",
                         label, i, (i == expected.size() - 1), words[i].last);
            end
        end
    endtask

    // Host reads the whole window, any word is a leak
    task automatic expect_quiet(input string label, input int cycles);
        receive_data_enable = 1'b1;
        repeat (cycles) begin
            @(posedge clock);
            #1;
            check_count++;
            if (receive_data_valid) begin
                error_count++;
                $display("[ERROR] %s receive_data_valid: expected 0x0 got 0x1", label);
            end
        end
        receive_data_enable = 1'b0;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_reset();
        byte_queue_t digits;
        logic [31:0] crc;
        for (int i = 0; i < 9; i++) begin
            digits.push_back(8'h31 + 8'(i));
        end
        crc = reference_crc(digits);
        check_count++;
        if (crc != 32'hCBF43926) begin
            error_count++;
            $display("[ERROR] reference_crc: expected 0xcbf43926 got 0x%08h", crc);
        end
        expect_quiet("reset", 50);
    endtask

    task automatic test_good_frame();
        byte_queue_t payload;
        byte_queue_t frame;
        word_queue_t words;
        random_payload(10 + int'($urandom % 51), payload);
        build_frame(payload, frame);
        drive_frame(frame, -1, 100);
        collect_frame(COLLECT_CYCLES, words);
        check_frame("good", payload, words);
    endtask

    task automatic test_bad_fcs();
        byte_queue_t payload;
        byte_queue_t frame;
        int          index;
        random_payload(10 + int'($urandom % 51), payload);
        build_frame(payload, frame);
        index = frame.size() - 1 - int'($urandom % 4);
        frame[index] = frame[index] ^ (8'h01 << ($urandom % 8));
        drive_frame(frame, -1, 100);
        expect_quiet("bad_fcs", 200);
        // Port must recover for the next frame
        test_good_frame();
    endtask

    task automatic test_receive_error();
        byte_queue_t payload;
        byte_queue_t frame;
        random_payload(10 + int'($urandom % 51), payload);
        build_frame(payload, frame);
        drive_frame(frame, 4 * (frame.size() / 2) + 1, 100);
        expect_quiet("rx_error", 200);
    endtask

    task automatic test_back_pressure();
        byte_queue_t first_payload;
        byte_queue_t second_payload;
        byte_queue_t frame;
        word_queue_t words;
        // Short payloads so the first move ends before the second SFD
        random_payload(10 + int'($urandom % 21), first_payload);
        random_payload(10 + int'($urandom % 21), second_payload);
        no_output_expected = 1'b1;
        build_frame(first_payload, frame);
        drive_frame(frame, -1, 100);
        build_frame(second_payload, frame);
        drive_frame(frame, -1, 200);
        no_output_expected = 1'b0;
        collect_frame(COLLECT_CYCLES, words);
        check_frame("held_first", first_payload, words);
        collect_frame(COLLECT_CYCLES, words);
        check_frame("held_second", second_payload, words);
    endtask

    initial begin
        clock                    = 1'b0;
        rst_n                    = 1'b0;
        rmii_receive_data        = 2'b00;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        receive_data_enable      = 1'b0;
        no_output_expected       = 1'b0;
        error_count              = 0;
        check_count              = 0;
        void'($urandom(75006));
        repeat (4) begin
            @(posedge clock);
        end
        #1;
        rst_n = 1'b1;
        test_reset();
        test_good_frame();
        test_bad_fcs();
        test_receive_error();
        test_back_pressure();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verif
rtl/rmii_rx_pkg.sv
rtl/rmii_byte_packager.sv
rtl/sync_fifo.sv
rtl/frame_check_sequence_generator.sv
rtl/ethernet_packet_parser.sv
rtl/receive_slot_handler.sv
rtl/rmii_port.sv
verif/rmii_port_tb.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= rmii_port_tb
FILELIST        ?= project.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verif/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)
